/* bench/sram_alloc_golden.txt */
# one operation per line, every field in hex, banks start with 256 free cells
# L mask 0 0 | R bank length 0 | Q length exp_bank dup | P length 0 0 | W exp_bank 0 0
# empty buffer, tie goes to the last scanned bank
Q 040 1f 0
Q 040 1f 0
# only bank 3 open, fill it with three 64-cell packets
L fffffff7 0 0
Q 1ff 03 0
Q 1ff 03 0
Q 1ff 03 0
L 00000000 0 0
# bank 3 holds the most packets, second strobe while busy is dropped
Q 008 03 1
# bank 3 has 62 cells left, too few for 64
Q 1ff 1f 0
# locked banks lose even with the most packets
L 00000008 0 0
Q 008 1f 0
L 80000008 0 0
Q 008 1e 0
# nothing qualifies until bank 3 gets cells back
L fffffff7 0 0
P 1ff 0 0
R 03 1ff 0
W 03 0 0
# banks 3 and 31 both at four packets
L 00000000 0 0
Q 040 1f 0
R 1f 040 0
R 1f 040 0
Q 008 03 1

/* bench/tb_sram_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sram_alloc;

    import sram_alloc_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 16;
    localparam int    TB_CELLS     = 256;           // small banks, a few grants fill one
    localparam int    WINDOW       = 32;            // one sweep over all banks
    localparam int    GRANT_LIMIT  = 4 * WINDOW;    // longest wait for a single grant
    localparam int    STALL_CYCLES = 3 * WINDOW;    // quiet time for a parked request
    localparam string GOLDEN_FILE  = "bench/sram_alloc_golden.txt";

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    pkt_len_t            req_length;
    logic                release_valid;
    sram_idx_t           release_sram;
    pkt_len_t            release_length;
    logic [SRAM_NUM-1:0] sram_lock;
    logic                busy;
    logic                grant_valid;
    sram_idx_t           grant_sram;

    // parsed golden operations
    logic [7:0]  op_q [$];
    logic [31:0] a_q  [$];
    logic [31:0] b_q  [$];
    logic [31:0] c_q  [$];

    bit ops_loaded = 1'b0;
    int grant_cnt  = 0;   // grant pulses seen
    int accept_cnt = 0;   // requests the DUT should accept

    sram_alloc_top #(
        .MATCH_THRESHOLD (31),
        .SRAM_CELLS      (TB_CELLS)
    ) sram_alloc_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_length     (req_length),
        .release_valid  (release_valid),
        .release_sram   (release_sram),
        .release_length (release_length),
        .sram_lock      (sram_lock),
        .busy           (busy),
        .grant_valid    (grant_valid),
        .grant_sram     (grant_sram)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every grant pulse, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && grant_valid)
            grant_cnt = grant_cnt + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting and checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_grant_sram(input sram_idx_t got, input sram_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] grant_sram got 0x%0h expected 0x%0h", got, exp);
            abort_run("grant went to the wrong bank");
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run("status level is wrong");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // golden file
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_golden();
        int          fd;
        int          ch;
        int          n;
        logic [7:0]  c8;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file");
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                c8 = ch[7:0];
                if (c8 == "#") begin
                    while (ch != -1 && ch[7:0] != 8'h0a)  // rest of the comment
                        ch = $fgetc(fd);
                end else if (c8 == "L" || c8 == "R" || c8 == "Q" || c8 == "P" ||
                             c8 == "W") begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    if (n != 3)
                        abort_run("golden line is missing operands");
                    op_q.push_back(c8);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                end else if (c8 != " " && c8 != 8'h0a && c8 != 8'h0d && c8 != 8'h09) begin
                    abort_run("golden file holds an unknown opcode");
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic idle_gap();
        int n;
        n = $urandom_range(3, 0);
        repeat (n) @(posedge clk);
    endtask

    task automatic issue_request(input pkt_len_t len, input bit dup);
        @(negedge clk);
        check_level("busy", busy, 1'b0);  // must be idle to be taken
        @(posedge clk);
        req_valid  <= 1'b1;
        req_length <= len;
        @(posedge clk);
        req_valid  <= 1'b0;
        accept_cnt++;
        @(negedge clk);
        check_level("busy", busy, 1'b1);
        if (dup) begin
            // lands mid-search, dropped by the DUT
            @(posedge clk);
            req_valid  <= 1'b1;
            req_length <= 9'h1ff;
            @(posedge clk);
            req_valid  <= 1'b0;
        end
    endtask

    task automatic pulse_release(input sram_idx_t bank, input pkt_len_t len);
        @(posedge clk);
        release_valid  <= 1'b1;
        release_sram   <= bank;
        release_length <= len;
        @(posedge clk);
        release_valid  <= 1'b0;
    endtask

    task automatic wait_grant(output sram_idx_t bank);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!grant_valid) begin
            if (cycles == GRANT_LIMIT)
                abort_run("no grant within four scan windows");
            cycles++;
            @(negedge clk);
        end
        bank = grant_sram;
        check_level("busy", busy, 1'b1);  // still busy in the grant cycle
    endtask

    // grant is one cycle, then back to idle
    task automatic finish_grant();
        @(negedge clk);
        check_level("grant_valid", grant_valid, 1'b0);
        check_level("busy", busy, 1'b0);
    endtask

    // parked request, no bank qualifies
    task automatic expect_stall();
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_level("busy", busy, 1'b1);
            check_level("grant_valid", grant_valid, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        sram_idx_t   bank;
        logic [7:0]  op;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_length     = '0;
        release_valid  = 1'b0;
        release_sram   = '0;
        release_length = '0;
        sram_lock      = '0;
        void'($urandom(64));
        load_golden();
        ops_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_level("busy", busy, 1'b0);
        check_level("grant_valid", grant_valid, 1'b0);

        for (int i = 0; i < op_q.size(); i++) begin
            op    = op_q[i];
            arg_a = a_q[i];
            arg_b = b_q[i];
            arg_c = c_q[i];
            case (op)
                "L": begin
                    @(posedge clk);
                    sram_lock <= arg_a;  // set bit = bank locked
                end
                "R": pulse_release(sram_idx_t'(arg_a), pkt_len_t'(arg_b));
                "Q": begin
                    issue_request(pkt_len_t'(arg_a), arg_c != 0);
                    wait_grant(bank);
                    check_grant_sram(bank, sram_idx_t'(arg_b));
                    finish_grant();
                end
                "P": begin
                    issue_request(pkt_len_t'(arg_a), 1'b0);
                    expect_stall();
                end
                "W": begin
                    wait_grant(bank);  // grant of the parked request
                    check_grant_sram(bank, sram_idx_t'(arg_a));
                    finish_grant();
                end
                default: abort_run("unknown opcode reached the sequencer");
            endcase
            idle_gap();
        end

        repeat (4) @(negedge clk);
        // one grant per accepted request, none for dropped strobes
        if (grant_cnt == accept_cnt) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("[FAIL] grant count got 0x%0h expected 0x%0h", grant_cnt, accept_cnt);
            $display("TB FAILED");
            $fatal(1, "grant count mismatch");
        end
    end

    // watchdog, four windows per golden line plus slack
    initial begin
        int limit;
        wait (ops_loaded);
        limit = op_q.size() * 4 * WINDOW + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog expired before the golden operations finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* common/sram_alloc_pkg.sv */
`default_nettype none

package sram_alloc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // buffer geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int SRAM_NUM   = 32;  // banks in the packet buffer
    localparam int SRAM_IDX_W = 5;   // bank index
    localparam int LEN_W      = 9;   // packet length in bytes
    localparam int CELL_W     = 11;  // free-cell counter, holds up to 2047
    localparam int PKT_W      = 9;   // packets per bank

    typedef logic [SRAM_IDX_W-1:0] sram_idx_t;
    typedef logic [LEN_W-1:0]      pkt_len_t;
    typedef logic [CELL_W-1:0]     cell_cnt_t;
    typedef logic [PKT_W-1:0]      pkt_cnt_t;

    // request controller
    typedef enum logic [1:0] {
        IDLE,   // waiting for req_valid
        MATCH,  // scan windows running
        GRANT   // one-cycle grant / commit
    } alloc_state_t;

    // window matcher
    typedef enum logic [1:0] {
        MS_IDLE,
        MS_SEARCH,
        MS_DONE
    } match_state_t;

    // cells taken by a packet: length bits 8..3 plus one
    function automatic cell_cnt_t len_to_cells(input pkt_len_t len);
        return cell_cnt_t'(len[LEN_W-1:3]) + cell_cnt_t'(1);
    endfunction

endpackage

`default_nettype wire

/* port_wr_sram_matcher/port_wr_sram_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module port_wr_sram_matcher #(
    parameter int MATCH_THRESHOLD = 31  // last tick of a scan window
) (
    input  wire  logic                      clk,
    input  wire  logic                      rst_n,

    // request side
    input  wire  sram_alloc_pkg::pkt_len_t  new_length,
    input  wire  logic                      match_enable,
    output logic                            match_suc,

    // scan pointer in, winner out
    input  wire  sram_alloc_pkg::sram_idx_t matching_sram,
    output sram_alloc_pkg::sram_idx_t       matching_best_sram,
    output logic                            update_matched_sram,

    // status of the bank under the pointer
    input  wire  logic                      accessible,
    input  wire  sram_alloc_pkg::cell_cnt_t free_space,
    input  wire  sram_alloc_pkg::pkt_cnt_t  packet_amount
);

    import sram_alloc_pkg::*;

    localparam int TICK_W = $clog2(MATCH_THRESHOLD + 1);
    localparam logic [TICK_W-1:0] LAST_TICK = MATCH_THRESHOLD[TICK_W-1:0];

    match_state_t      match_state;
    logic [TICK_W-1:0] matching_tick;  // position inside the window
    logic              matching_find;  // some bank recorded this window
    pkt_cnt_t          max_amount;     // packet count of the recorded bank
    cell_cnt_t         need_cells;
    logic              bank_ok;        // current bank can take the packet
    logic              window_end;

    assign need_cells = len_to_cells(new_length);
    assign bank_ok    = accessible && (free_space >= need_cells);
    assign window_end = match_enable && (matching_tick == LAST_TICK);

    // level seen by the controller as "candidate seen"
    assign update_matched_sram = match_enable && !match_suc && matching_find;

    ////////////////////////////////////////////////////////////////////////////
    // window FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_state <= MS_IDLE;
            match_suc   <= 1'b0;
        end else begin
            case (match_state)
                MS_IDLE: begin
                    if (match_enable)
                        match_state <= MS_SEARCH;
                end
                MS_SEARCH: begin
                    // last bank of the window still counts as a find
                    if (window_end && (matching_find || bank_ok)) begin
                        match_suc   <= 1'b1;
                        match_state <= MS_DONE;
                    end
                end
                MS_DONE: begin
                    match_suc   <= 1'b0;  // single-cycle pulse
                    match_state <= MS_IDLE;
                end
                default: match_state <= MS_IDLE;
            endcase
        end
    end

    // tick runs in step with the scan pointer, restarts every window
    always_ff @(posedge clk) begin
        if (!rst_n)
            matching_tick <= '0;
        else if (match_enable && matching_tick != LAST_TICK)
            matching_tick <= matching_tick + 1'b1;
        else
            matching_tick <= '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // best-bank tracking
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n || !match_enable || match_suc) begin
            matching_find <= 1'b0;  // fresh record for the next request
            max_amount    <= '0;
        end else if (bank_ok && packet_amount >= max_amount) begin
            max_amount    <= packet_amount;  // >= so a later bank wins a tie
            matching_find <= 1'b1;
        end
    end

    // winner index, held through match_suc
    always_ff @(posedge clk) begin
        if (match_enable && !match_suc && bank_ok && packet_amount >= max_amount)
            matching_best_sram <= matching_sram;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the write-port allocator testbench with verilator
# exit status is nonzero whenever the testbench ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_sram_alloc \
    -f sim.f \
    -o tb_sram_alloc
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/tb_sram_alloc
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi

exit 0

/* sim.f */
common/sram_alloc_pkg.sv
port_wr_sram_matcher/port_wr_sram_matcher.sv
verilog/sram_status_table.sv
verilog/port_wr_alloc_ctrl.sv
verilog/sram_alloc_top.sv
bench/tb_sram_alloc.sv

/* verilog/port_wr_alloc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module port_wr_alloc_ctrl #(
    parameter int MATCH_THRESHOLD = 31  // same window length as the matcher
) (
    input  wire  logic                      clk,
    input  wire  logic                      rst_n,

    // write port request
    input  wire  logic                      req_valid,
    input  wire  sram_alloc_pkg::pkt_len_t  req_length,

    // from matcher
    input  wire  logic                      match_suc,
    input  wire  sram_alloc_pkg::sram_idx_t matching_best_sram,
    input  wire  logic                      update_matched_sram,  // candidate seen

    // to matcher / status table
    output logic                            match_enable,
    output sram_alloc_pkg::pkt_len_t        new_length,
    output sram_alloc_pkg::sram_idx_t       scan_sram,

    // to outside
    output logic                            busy,
    output logic                            grant_valid,
    output sram_alloc_pkg::sram_idx_t       grant_sram,

    // charge to status table
    output logic                            commit_valid,
    output sram_alloc_pkg::sram_idx_t       commit_sram,
    output sram_alloc_pkg::pkt_len_t        commit_length
);

    import sram_alloc_pkg::*;

    localparam sram_idx_t LAST_SRAM = sram_idx_t'(MATCH_THRESHOLD);  // window end

    alloc_state_t state;
    logic         window_end;
    sram_idx_t    scan_inc;   // wrapping increment

    assign window_end = (scan_sram == LAST_SRAM);
    assign scan_inc   = (scan_sram == sram_idx_t'(SRAM_NUM - 1)) ? '0 : scan_sram + 1'b1;

    assign match_enable  = (state == MATCH);
    assign busy          = (state != IDLE);
    assign grant_valid   = (state == GRANT);
    assign commit_valid  = (state == GRANT);  // charge together with the grant
    assign commit_sram   = grant_sram;
    assign commit_length = new_length;

    ////////////////////////////////////////////////////////////////////////////
    // request FSM and scan pointer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            scan_sram <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin  // strobes while busy never get here
                        state     <= MATCH;
                        scan_sram <= '0;
                    end
                end
                MATCH: begin
                    if (match_suc) begin
                        state <= GRANT;
                    end else if (window_end) begin
                        // empty window, retry sweeps from bank 0 again
                        if (!update_matched_sram)
                            scan_sram <= '0;
                        else
                            scan_sram <= scan_inc;
                    end else begin
                        scan_sram <= scan_inc;
                    end
                end
                GRANT: state <= IDLE;  // one grant cycle only
                default: state <= IDLE;
            endcase
        end
    end

    // request payload, held for the whole search
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid)
            new_length <= req_length;
        if (state == MATCH && match_suc)
            grant_sram <= matching_best_sram;  // best bank valid with match_suc
    end

endmodule

`default_nettype wire

/* verilog/sram_alloc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_alloc_top #(
    parameter int MATCH_THRESHOLD = 31,   // 31 -> one window covers all banks
    parameter int SRAM_CELLS      = 1024
) (
    input  wire  logic                                clk,
    input  wire  logic                                rst_n,
    input  wire  logic                                req_valid,
    input  wire  sram_alloc_pkg::pkt_len_t            req_length,
    input  wire  logic                                release_valid,
    input  wire  sram_alloc_pkg::sram_idx_t           release_sram,
    input  wire  sram_alloc_pkg::pkt_len_t            release_length,
    input  wire  logic [sram_alloc_pkg::SRAM_NUM-1:0] sram_lock,
    output logic                                      busy,
    output logic                                      grant_valid,
    output sram_alloc_pkg::sram_idx_t                 grant_sram
);

    import sram_alloc_pkg::*;

    // controller <-> matcher
    logic      match_enable;
    pkt_len_t  new_length;
    sram_idx_t scan_sram;
    logic      match_suc;
    sram_idx_t matching_best_sram;
    logic      update_matched_sram;

    // status table read
    logic      accessible;
    cell_cnt_t free_space;
    pkt_cnt_t  packet_amount;

    // charge path
    logic      commit_valid;
    sram_idx_t commit_sram;
    pkt_len_t  commit_length;

    port_wr_alloc_ctrl #(
        .MATCH_THRESHOLD (MATCH_THRESHOLD)
    ) u_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .req_valid           (req_valid),
        .req_length          (req_length),
        .match_suc           (match_suc),
        .matching_best_sram  (matching_best_sram),
        .update_matched_sram (update_matched_sram),
        .match_enable        (match_enable),
        .new_length          (new_length),
        .scan_sram           (scan_sram),
        .busy                (busy),
        .grant_valid         (grant_valid),
        .grant_sram          (grant_sram),
        .commit_valid        (commit_valid),
        .commit_sram         (commit_sram),
        .commit_length       (commit_length)
    );

    port_wr_sram_matcher #(
        .MATCH_THRESHOLD (MATCH_THRESHOLD)
    ) u_matcher (
        .clk                 (clk),
        .rst_n               (rst_n),
        .new_length          (new_length),
        .match_enable        (match_enable),
        .match_suc           (match_suc),
        .matching_sram       (scan_sram),
        .matching_best_sram  (matching_best_sram),
        .update_matched_sram (update_matched_sram),
        .accessible          (accessible),
        .free_space          (free_space),
        .packet_amount       (packet_amount)
    );

    sram_status_table #(
        .SRAM_CELLS (SRAM_CELLS)
    ) u_status (
        .clk            (clk),
        .rst_n          (rst_n),
        .scan_sram      (scan_sram),
        .sram_lock      (sram_lock),
        .accessible     (accessible),
        .free_space     (free_space),
        .packet_amount  (packet_amount),
        .commit_valid   (commit_valid),
        .commit_sram    (commit_sram),
        .commit_length  (commit_length),
        .release_valid  (release_valid),
        .release_sram   (release_sram),
        .release_length (release_length)
    );

endmodule

`default_nettype wire

/* verilog/sram_status_table.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_status_table #(
    parameter int SRAM_CELLS = 1024  // free cells per bank out of reset
) (
    input  wire  logic                                clk,
    input  wire  logic                                rst_n,

    // scan read port
    input  wire  sram_alloc_pkg::sram_idx_t           scan_sram,
    input  wire  logic [sram_alloc_pkg::SRAM_NUM-1:0] sram_lock,
    output logic                                      accessible,
    output sram_alloc_pkg::cell_cnt_t                 free_space,
    output sram_alloc_pkg::pkt_cnt_t                  packet_amount,

    // charge from the allocator
    input  wire  logic                                commit_valid,
    input  wire  sram_alloc_pkg::sram_idx_t           commit_sram,
    input  wire  sram_alloc_pkg::pkt_len_t            commit_length,

    // credit from the read side
    input  wire  logic                                release_valid,
    input  wire  sram_alloc_pkg::sram_idx_t           release_sram,
    input  wire  sram_alloc_pkg::pkt_len_t            release_length
);

    import sram_alloc_pkg::*;

    cell_cnt_t free_cells [SRAM_NUM];  // per-bank free cells
    pkt_cnt_t  pkt_amount [SRAM_NUM];  // per-bank packets stored
    cell_cnt_t free_nxt   [SRAM_NUM];
    pkt_cnt_t  pkt_nxt    [SRAM_NUM];

    cell_cnt_t commit_cells;
    cell_cnt_t release_cells;

    assign commit_cells  = len_to_cells(commit_length);
    assign release_cells = len_to_cells(release_length);

    ////////////////////////////////////////////////////////////////////////////
    // scan read, combinational
    ////////////////////////////////////////////////////////////////////////////
    assign accessible    = !sram_lock[scan_sram];  // lock bit set -> skip
    assign free_space    = free_cells[scan_sram];
    assign packet_amount = pkt_amount[scan_sram];

    ////////////////////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////////////////////
    // commit and release may land on the same bank, both apply
    always_comb begin
        for (int i = 0; i < SRAM_NUM; i++) begin
            free_nxt[i] = free_cells[i];
            pkt_nxt[i]  = pkt_amount[i];
            if (commit_valid && commit_sram == sram_idx_t'(i)) begin
                free_nxt[i] = free_nxt[i] - commit_cells;
                pkt_nxt[i]  = pkt_nxt[i] + 1'b1;
            end
            if (release_valid && release_sram == sram_idx_t'(i)) begin
                free_nxt[i] = free_nxt[i] + release_cells;
                pkt_nxt[i]  = pkt_nxt[i] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SRAM_NUM; i++) begin
                free_cells[i] <= cell_cnt_t'(SRAM_CELLS);  // every bank empty
                pkt_amount[i] <= '0;
            end
        end else begin
            for (int i = 0; i < SRAM_NUM; i++) begin
                free_cells[i] <= free_nxt[i];
                pkt_amount[i] <= pkt_nxt[i];
            end
        end
    end

endmodule

`default_nettype wire
